/* boardPkg.sv */
package boardPkg;

    localparam int WordAddrBits = 30;     // processor data bus is word addressed
    localparam int LedWidth = 14;
    localparam int SwitchWidth = 8;

    typedef logic [31:0] dataWord;
    typedef logic [3:0] byteEnable;       // bit n enables byte n of a data word

    // address bits 29:26 equal to this select the devices
    localparam logic [3:0] MmioRegion = 4'd11;

    // device select in address bits 25:23
    // codes 0 to 3 and 7 have no device behind them
    typedef enum logic [2:0] {
        DevLed = 3'd4,
        DevSwitch = 3'd5,
        DevRotary = 3'd6
    } deviceId;

    typedef struct packed {
        logic [3:0] region;               // address bits 29:26
        deviceId device;                  // address bits 25:23
        logic [22:0] offset;              // register offset inside a device
    } mmioFields;

    // one data word address, seen as a plain memory index or as
    // region and device fields when it falls in the device region
    typedef union packed {
        logic [WordAddrBits-1:0] memWord;
        mmioFields mmio;
    } busAddrT;

endpackage

/* wordMemory.sv */
`timescale 1ns/1ps

module wordMemory import boardPkg::*;
#(
    parameter int MemAddrBits = 10        // 4 to 14 word address bits
)
(
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [MemAddrBits-1:0] addr,
    input  logic                   read,
    input  logic                   write,
    input  byteEnable              be,
    input  dataWord                writeData,
    output dataWord                readData,
    output logic                   ready
);

    localparam int Depth = 2 ** MemAddrBits;

    dataWord mem [Depth];

    logic access;

    assign access = read || write;

    // byte-enabled write, done once in the first cycle of the access
    always_ff @(posedge clock)
    begin
        if (write && !ready)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (be[i])
                    mem[addr][8*i +: 8] <= writeData[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (read)
            readData <= mem[addr];        // valid while ready is high
    end

    // one ready pulse per access, master drops the strobe after it
    always_ff @(posedge clock)
    begin
        if (!rstN)
            ready <= 1'b0;
        else
            ready <= access && !ready;
    end

    // the decoder passes the master strobes straight through
    noReadWithWrite: assert property (
        @(posedge clock) disable iff (!rstN)
        !(read && write)
    ) else $error("memory read and write strobes high together");

endmodule

/* busDecoder.sv */
`timescale 1ns/1ps

module busDecoder import boardPkg::*;
#(
    parameter int MemAddrBits = 10
)
(
    input  busAddrT                busAddr,
    input  logic                   readWord,
    input  logic                   writeWord,
    input  byteEnable              writeBe,
    input  dataWord                writeData,
    output dataWord                readData,
    output logic                   ready,
    output logic [MemAddrBits-1:0] memAddr,
    output logic                   memRead,
    output logic                   memWrite,
    output byteEnable              memBe,
    output dataWord                memWriteData,
    input  dataWord                memReadData,
    input  logic                   memReady,
    output logic                   ledRead,
    output logic                   ledWrite,
    output logic [LedWidth-1:0]    ledData,
    input  logic [LedWidth-1:0]    ledReadData,
    input  logic                   ledReady,
    output logic                   swRead,
    input  logic [SwitchWidth-1:0] swReadData,
    input  logic                   swReady,
    output logic                   rotRead,
    input  logic                   rotReadData,
    input  logic                   rotReady
);

    logic isMmio;
    logic fullWord;

    assign isMmio = busAddr.mmio.region == MmioRegion;
    assign fullWord = &writeBe;           // devices only take whole words

    assign memAddr = busAddr.memWord[MemAddrBits-1:0];
    assign memBe = writeBe;
    assign memWriteData = writeData;
    assign ledData = writeData[LedWidth-1:0];

    always_comb
    begin
        memRead = 1'b0;
        memWrite = 1'b0;
        ledRead = 1'b0;
        ledWrite = 1'b0;
        swRead = 1'b0;
        rotRead = 1'b0;
        readData = '0;
        ready = 1'b0;
        if (!isMmio)
        begin
            memRead = readWord;
            memWrite = writeWord;
            readData = memReadData;
            ready = memReady;
        end
        else
        begin
            case (busAddr.mmio.device)
                DevLed:
                begin
                    ledWrite = writeWord && fullWord;
                    // a partial write runs as a read so it still gets its ready
                    ledRead = readWord || (writeWord && !fullWord);
                    readData = dataWord'(ledReadData);
                    ready = ledReady;
                end
                DevSwitch:
                begin
                    swRead = readWord || writeWord;    // read only, writes just acked
                    readData = dataWord'(swReadData);
                    ready = swReady;
                end
                DevRotary:
                begin
                    rotRead = readWord || writeWord;
                    readData = dataWord'(rotReadData);
                    ready = rotReady;
                end
                default:
                begin
                    readData = '0;        // no device, access never ends
                    ready = 1'b0;
                end
            endcase
        end
        // also catches a master that raises both strobes at once
        if (!$isunknown({readWord, writeWord, busAddr}))
            assert ($onehot0({memRead, memWrite, ledRead, ledWrite, swRead, rotRead}))
            else $error("more than one target strobe high");
    end

endmodule

/* ledPort.sv */
`timescale 1ns/1ps

module ledPort import boardPkg::*;
(
    input  logic                clock,
    input  logic                rstN,
    input  logic                write,
    input  logic                read,
    input  logic [LedWidth-1:0] writeData,
    output logic [LedWidth-1:0] readData,
    output logic                ready,
    output logic [LedWidth-1:0] leds
);

    logic [LedWidth-1:0] ledReg;

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            ledReg <= '0;
            ready <= 1'b0;
        end
        else
        begin
            if (write)
                ledReg <= writeData;      // same value on the held cycle
            ready <= (read || write) && !ready;
        end
    end

    assign readData = ledReg;
    assign leds = ledReg;

endmodule

/* switchFilter.sv */
`timescale 1ns/1ps

module switchFilter import boardPkg::*;
#(
    parameter int DebounceCycles = 4
)
(
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   read,
    input  logic [SwitchWidth-1:0] switchPins,
    output logic [SwitchWidth-1:0] switchState,
    output logic                   ready
);

    localparam int CountBits = $clog2(DebounceCycles + 1);
    localparam logic [CountBits-1:0] CountDone = CountBits'(DebounceCycles);

    logic [SwitchWidth-1:0] syncFirst;
    logic [SwitchWidth-1:0] syncSecond;
    logic [SwitchWidth-1:0] syncLast;     // previous synchronised value
    logic [CountBits-1:0] stableCount;

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            syncFirst <= '0;
            syncSecond <= '0;
            syncLast <= '0;
            stableCount <= '0;
            switchState <= '0;
            ready <= 1'b0;
        end
        else
        begin
            syncFirst <= switchPins;      // pins are asynchronous
            syncSecond <= syncFirst;
            syncLast <= syncSecond;
            if (syncSecond != syncLast)
                stableCount <= '0;        // any bounce restarts the wait
            else if (stableCount != CountDone)
                stableCount <= stableCount + 1'b1;
            if (stableCount == CountDone)
                switchState <= syncLast;
            ready <= read && !ready;
        end
    end

endmodule

/* rotaryDecoder.sv */
`timescale 1ns/1ps

module rotaryDecoder
(
    input  logic       clock,
    input  logic       rstN,
    input  logic       read,
    input  logic [1:0] rotaryPins,        // bit 0 phase A, bit 1 phase B
    output logic       ready,
    output logic       rotaryEvent,
    output logic       directionRight
);

    logic [1:0] syncFirst;
    logic [1:0] syncSecond;
    logic prevA;
    logic aRise;

    assign aRise = syncSecond[0] && !prevA;

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            syncFirst <= '0;
            syncSecond <= '0;
            prevA <= 1'b0;
        end
        else
        begin
            syncFirst <= rotaryPins;
            syncSecond <= syncFirst;
            prevA <= syncSecond[0];
        end
    end

    always_ff @(posedge clock)
    begin
        if (!rstN)
        begin
            rotaryEvent <= 1'b0;
            directionRight <= 1'b0;
            ready <= 1'b0;
        end
        else
        begin
            if (read && !ready)
                rotaryEvent <= 1'b0;      // read acknowledges the step
            if (aRise)
            begin
                rotaryEvent <= 1'b1;      // a fresh step wins over the clear
                directionRight <= !syncSecond[1];
            end
            ready <= read && !ready;
        end
    end

    // the flag can only be raised by a low to high step of synchronised phase A
    eventNeedsEdge: assert property (
        @(posedge clock) disable iff (!rstN)
        $rose(rotaryEvent) |-> $past(syncSecond[0]) && !$past(syncSecond[0], 2)
    ) else $error("rotary event raised without a phase A edge");

endmodule

/* systemBoard.sv */
`timescale 1ns/1ps

module systemBoard import boardPkg::*;
#(
    parameter int MemAddrBits = 10,
    parameter int DebounceCycles = 4
)
(
    input  logic                   clock,
    input  logic                   rstN,
    input  busAddrT                busAddr,
    input  logic                   readWord,
    input  logic                   writeWord,
    input  byteEnable              writeBe,
    input  dataWord                writeData,
    output dataWord                readData,
    output logic                   ready,
    input  logic [SwitchWidth-1:0] switches,
    input  logic [1:0]             rotary,
    output logic [LedWidth:0]      leds,
    output logic [3:0]             interrupts,
    output logic                   nmi
);

    logic [MemAddrBits-1:0] memAddr;
    logic memRead;
    logic memWrite;
    byteEnable memBe;
    dataWord memWriteData;
    dataWord memReadData;
    logic memReady;
    logic ledRead;
    logic ledWrite;
    logic [LedWidth-1:0] ledData;
    logic [LedWidth-1:0] ledReadData;
    logic ledReady;
    logic [LedWidth-1:0] ledPins;
    logic swRead;
    logic swReady;
    logic [SwitchWidth-1:0] switchState;
    logic rotRead;
    logic rotReady;
    logic rotaryEvent;
    logic directionRight;

    assign leds = {1'b0, ledPins};        // top LED is not wired to a register
    assign interrupts = {switchState[7:5], rotaryEvent};
    assign nmi = switchState[3];

    busDecoder #(.MemAddrBits(MemAddrBits)) decoder (
        .busAddr(busAddr), .readWord(readWord), .writeWord(writeWord),
        .writeBe(writeBe), .writeData(writeData), .readData(readData), .ready(ready),
        .memAddr(memAddr), .memRead(memRead), .memWrite(memWrite), .memBe(memBe),
        .memWriteData(memWriteData), .memReadData(memReadData), .memReady(memReady),
        .ledRead(ledRead), .ledWrite(ledWrite), .ledData(ledData),
        .ledReadData(ledReadData), .ledReady(ledReady),
        .swRead(swRead), .swReadData(switchState), .swReady(swReady),
        .rotRead(rotRead), .rotReadData(directionRight), .rotReady(rotReady)
    );

    wordMemory #(.MemAddrBits(MemAddrBits)) mainMemory (
        .clock(clock), .rstN(rstN), .addr(memAddr), .read(memRead), .write(memWrite),
        .be(memBe), .writeData(memWriteData), .readData(memReadData), .ready(memReady)
    );

    ledPort ledRegister (
        .clock(clock), .rstN(rstN), .write(ledWrite), .read(ledRead),
        .writeData(ledData), .readData(ledReadData), .ready(ledReady), .leds(ledPins)
    );

    switchFilter #(.DebounceCycles(DebounceCycles)) switchInput (
        .clock(clock), .rstN(rstN), .read(swRead), .switchPins(switches),
        .switchState(switchState), .ready(swReady)
    );

    rotaryDecoder rotaryInput (
        .clock(clock), .rstN(rstN), .read(rotRead), .rotaryPins(rotary),
        .ready(rotReady), .rotaryEvent(rotaryEvent), .directionRight(directionRight)
    );

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock
(
    output logic clock,
    output logic rstN
);

    initial
    begin
        clock = 1'b0;
        forever #2 clock = !clock;        // 4 ns period
    end

    initial
    begin
        rstN = 1'b0;
        repeat (2) @(posedge clock);
        rstN <= 1'b1;                     // low for two rising edges
    end

endmodule

/* systemBoardTb.sv */
`timescale 1ns/1ps

module systemBoardTb import boardPkg::*;
();

    localparam int MemAddrBits = 10;
    localparam int MemWrites = 200;
    localparam int LedTrials = 8;
    localparam int SwitchTrials = 8;
    localparam int RotaryTrials = 8;
    localparam int TotalAccesses = 2 * MemWrites + 4 * LedTrials + 2 * SwitchTrials
                                   + RotaryTrials + 2;
    localparam int WatchdogCycles = TotalAccesses * 10 + 2000;
    localparam int AccessLimit = 16;      // cycles a live target may take

    logic clock;
    logic rstN;
    busAddrT busAddr;
    logic readWord;
    logic writeWord;
    byteEnable writeBe;
    dataWord writeData;
    dataWord readData;
    logic ready;
    logic [SwitchWidth-1:0] switches;
    logic [1:0] rotary;
    logic [LedWidth:0] leds;
    logic [3:0] interrupts;
    logic nmi;

    dataWord memModel [2 ** MemAddrBits];
    bit memWritten [2 ** MemAddrBits];
    logic [MemAddrBits-1:0] writtenIdx [$];   // indices safe to read back
    logic [LedWidth-1:0] ledModel;
    logic [SwitchWidth-1:0] switchModel;
    logic rotEventModel;
    logic rotDirModel;
    logic [31:0] lcgState = 32'd54;

    tbClock clockGen (.clock(clock), .rstN(rstN));

    systemBoard #(.MemAddrBits(MemAddrBits), .DebounceCycles(4)) dut (
        .clock(clock), .rstN(rstN), .busAddr(busAddr), .readWord(readWord),
        .writeWord(writeWord), .writeBe(writeBe), .writeData(writeData),
        .readData(readData), .ready(ready), .switches(switches), .rotary(rotary),
        .leds(leds), .interrupts(interrupts), .nmi(nmi)
    );

    function automatic logic [31:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return {lcgState[15:0], lcgState[31:16]};    // low state bits repeat quickly
    endfunction

    // random alias bits above the index, any region but the device one
    function automatic busAddrT memAddrFor(input logic [MemAddrBits-1:0] index);
        busAddrT a;
        a.memWord = WordAddrBits'(nextRandom());
        a.memWord[MemAddrBits-1:0] = index;
        if (a.mmio.region == MmioRegion)
            a.mmio.region = 4'd0;
        return a;
    endfunction

    function automatic busAddrT deviceAddr(input logic [2:0] device);
        busAddrT a;
        a.memWord = WordAddrBits'(nextRandom());    // random register offset
        a.mmio.region = MmioRegion;
        a.mmio.device = deviceId'(device);
        return a;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected)
        begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // one bus access as the master, ready seen at the falling edge
    task automatic busAccess(input busAddrT addr, input logic isWrite, input byteEnable be,
                             input dataWord data, output dataWord rdata);
        int waitCycles;
        waitCycles = 0;
        @(posedge clock);
        busAddr <= addr;
        readWord <= !isWrite;
        writeWord <= isWrite;
        writeBe <= be;
        writeData <= data;
        @(negedge clock);
        while (!ready)
        begin
            waitCycles++;
            if (waitCycles > AccessLimit)
            begin
                $display("bus access to %h got no ready within %0d cycles", addr,
                         AccessLimit);
                $display("*** FAILED ***");
                $fatal(1, "bus access timeout");
            end
            @(negedge clock);
        end
        checkValue(32'(waitCycles), 1, "ready latency");
        rdata = readData;
        @(posedge clock);
        readWord <= 1'b0;                 // drop in the cycle after ready
        writeWord <= 1'b0;
        @(negedge clock);
        checkValue(32'(ready), 0, "ready pulse wider than one cycle");
    endtask

    task automatic memoryTraffic();
        logic [31:0] r;
        logic [MemAddrBits-1:0] idx;
        byteEnable be;
        dataWord data;
        dataWord rdata;
        for (int n = 0; n < MemWrites; n++)
        begin
            r = nextRandom();
            idx = r[MemAddrBits-1:0];
            be = r[19:16];
            if (!memWritten[idx])
            begin
                be = 4'hf;                // first write sets every byte
                memWritten[idx] = 1'b1;
                writtenIdx.push_back(idx);
            end
            data = nextRandom();
            busAccess(memAddrFor(idx), 1'b1, be, data, rdata);
            for (int i = 0; i < 4; i++)
            begin
                if (be[i])
                    memModel[idx][8*i +: 8] = data[8*i +: 8];
            end
            r = nextRandom();
            idx = writtenIdx[r % writtenIdx.size()];
            busAccess(memAddrFor(idx), 1'b0, 4'h0, '0, rdata);
            checkValue(rdata, memModel[idx], "memory read data");
        end
    endtask

    task automatic ledRegisterTest();
        dataWord data;
        dataWord rdata;
        byteEnable be;
        for (int n = 0; n < LedTrials; n++)
        begin
            data = nextRandom();
            busAccess(deviceAddr(DevLed), 1'b1, 4'hf, data, rdata);
            ledModel = data[LedWidth-1:0];
            checkValue(32'(leds), 32'(ledModel), "leds after full write");
            busAccess(deviceAddr(DevLed), 1'b0, 4'h0, '0, rdata);
            checkValue(rdata, 32'(ledModel), "LED read back");
            data = nextRandom();
            be = (data[3:0] == 4'hf) ? 4'h7 : data[3:0];
            busAccess(deviceAddr(DevLed), 1'b1, be, ~data, rdata);    // ignored by the port
            checkValue(32'(leds), 32'(ledModel), "leds after partial write");
            busAccess(deviceAddr(DevLed), 1'b0, 4'h0, '0, rdata);
            checkValue(rdata, 32'(ledModel), "LED read after partial write");
        end
    endtask

    task automatic switchDebounceTest();
        logic [31:0] r;
        logic [SwitchWidth-1:0] mask;
        dataWord rdata;
        for (int n = 0; n < SwitchTrials; n++)
        begin
            r = nextRandom();
            switchModel = r[SwitchWidth-1:0];
            mask = r[15:8] | 8'h08;       // glitch always reaches nmi
            @(posedge clock);
            switches <= switchModel;
            repeat (20) @(posedge clock);
            @(negedge clock);
            checkValue(32'(interrupts[3:1]), 32'(switchModel[7:5]), "switch interrupts");
            checkValue(32'(nmi), 32'(switchModel[3]), "nmi from switch 3");
            busAccess(deviceAddr(DevSwitch), 1'b0, 4'h0, '0, rdata);
            checkValue(rdata, 32'(switchModel), "switch read");
            @(posedge clock);
            switches <= switchModel ^ mask;       // two cycle glitch
            repeat (2) @(posedge clock);
            switches <= switchModel;
            repeat (12)
            begin
                @(negedge clock);
                checkValue(32'(nmi), 32'(switchModel[3]), "nmi during glitch");
                checkValue(32'(interrupts[3:1]), 32'(switchModel[7:5]),
                           "switch interrupts during glitch");
            end
            repeat (8) @(posedge clock);
            busAccess(deviceAddr(DevSwitch), 1'b0, 4'h0, '0, rdata);
            checkValue(rdata, 32'(switchModel), "switch read after glitch");
        end
    endtask

    task automatic rotaryStepTest();
        logic [31:0] r;
        logic phaseB;
        dataWord rdata;
        for (int n = 0; n < RotaryTrials; n++)
        begin
            r = nextRandom();
            phaseB = r[0];
            @(posedge clock);
            rotary <= {phaseB, 1'b0};
            repeat (6) @(posedge clock);
            rotary <= {phaseB, 1'b1};     // phase A rises
            repeat (6) @(posedge clock);
            rotEventModel = 1'b1;
            rotDirModel = !phaseB;        // B low at the A edge is a right turn
            @(negedge clock);
            checkValue(32'(interrupts[0]), 32'(rotEventModel), "rotary interrupt after step");
            busAccess(deviceAddr(DevRotary), 1'b0, 4'h0, '0, rdata);
            checkValue(rdata, 32'(rotDirModel), "rotary direction");
            rotEventModel = 1'b0;
            checkValue(32'(interrupts[0]), 32'(rotEventModel), "rotary interrupt after read");
            @(posedge clock);
            rotary <= {phaseB, 1'b0};
            repeat (6) @(posedge clock);
        end
    endtask

    task automatic invalidDeviceTest();
        logic [MemAddrBits-1:0] idx;
        dataWord rdata;
        @(posedge clock);
        busAddr <= deviceAddr(3'd2);
        readWord <= 1'b1;
        repeat (8)
        begin
            @(negedge clock);
            checkValue(32'(ready), 0, "ready from invalid device");
            checkValue(readData, 0, "read data from invalid device");
        end
        @(posedge clock);
        readWord <= 1'b0;                 // master gives up
        @(negedge clock);
        checkValue(32'(ready), 0, "ready after abandoned access");
        idx = writtenIdx[0];
        busAccess(memAddrFor(idx), 1'b0, 4'h0, '0, rdata);
        checkValue(rdata, memModel[idx], "memory read after invalid access");
    endtask

    initial
    begin
        busAddr = '0;
        readWord = 1'b0;
        writeWord = 1'b0;
        writeBe = '0;
        writeData = '0;
        switches = '0;
        rotary = 2'b00;
        ledModel = '0;
        switchModel = '0;
        rotEventModel = 1'b0;
        rotDirModel = 1'b0;
        wait (rstN === 1'b1);
        @(negedge clock);
        checkValue(32'({ready, nmi, interrupts, leds}), 0, "outputs after reset");
        memoryTraffic();
        ledRegisterTest();
        switchDebounceTest();
        rotaryStepTest();
        invalidDeviceTest();
        $display("*** PASSED ***");
        $finish;
    end

    initial
    begin
        repeat (WatchdogCycles) @(posedge clock);
        $display("watchdog expired, tests did not finish in %0d clock periods",
                 WatchdogCycles);
        $display("*** FAILED ***");
        $fatal(1, "watchdog timeout");
    end

endmodule

/* files.f */
boardPkg.sv
wordMemory.sv
busDecoder.sv
ledPort.sv
switchFilter.sv
rotaryDecoder.sv
systemBoard.sv
tbClock.sv
systemBoardTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module systemBoardTb -f files.f -o simv

./obj_dir/simv | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
